//--- verilog/stepper_pkg.sv
// Shared types, register map and sizes for the stepper output subsystem
// Every block refers to these by scoped name

package stepper_pkg;

    ////////////////////////////////////////
    // Sizes

    localparam int QUEUE_DEPTH   = 8;   // Host side move FIFO
    localparam int SCHED_CREDITS = 2;   // Scheduler buffer slots

    ////////////////////////////////////////
    // Register map (word addresses)

    localparam logic [3:0] ADDR_POLARITY     = 4'd0;
    localparam logic [3:0] ADDR_CLR_SHUTDOWN = 4'd1;
    localparam logic [3:0] ADDR_STEP_DUR     = 4'd2;
    localparam logic [3:0] ADDR_PUSH_MOVE    = 4'd3;
    localparam logic [3:0] ADDR_STATUS       = 4'd4;

    ////////////////////////////////////////
    // Plain vector types

    typedef logic [7:0]  pin_vec_t;     // Pin levels or polarity bits
    typedef logic [15:0] step_dur_t;    // Step pulse width, clocks
    typedef logic [15:0] interval_t;    // Step start to step start, clocks
    typedef logic [14:0] step_count_t;  // Steps in one move
    typedef logic [3:0]  qcount_t;      // Queue fill level or free slots

    // Move entry, same bit layout as the push register data word
    // interval in [31:16], count in [15:1], dir in [0]
    typedef struct packed {
        interval_t   interval;
        step_count_t count;
        logic        dir;
    } move_entry_t;

    // One cycle write strobes from the bus decoder
    typedef struct packed {
        logic        set_polarity;
        logic        clear_shutdown;
        logic        set_step_dur;
        logic        push_move;
        logic [31:0] data;      // Raw write data
    } reg_cmd_t;

    // Status word, returned zero extended on a status read
    typedef struct packed {
        qcount_t free;          // Free queue slots
        logic    in_shutdown;
        logic    busy;          // Scheduler has work
        logic    overflow;      // Sticky, cleared by reading status
    } status_t;

    // Step scheduler FSM
    typedef enum logic [1:0] {
        IDLE,   // Waiting for a buffered entry
        WAIT,   // Counting down the interval
        STEP    // Issuing one step request
    } sched_state_e;

endpackage

//--- verilog/wb_stepper_regs.sv
// Wishbone slave for the stepper block: turns bus writes into one cycle commands
// and returns the status word, with a registered single cycle ack
`timescale 1ns/1ns

module wb_stepper_regs (
    input  logic                 clk,
    input  logic                 rst,

    input  logic                 wb_cyc_i,
    input  logic                 wb_stb_i,
    input  logic                 wb_we_i,
    input  logic [3:0]           wb_adr_i,
    input  logic [31:0]          wb_dat_i,
    output logic [31:0]          wb_dat_o,
    output logic                 wb_ack_o,

    output stepper_pkg::reg_cmd_t cmd_o,
    input  stepper_pkg::status_t  status_i,
    output logic                 status_read_o
);

    logic        ack_q;
    logic [31:0] rd_data_q;
    logic        req;           // Strobe seen for the first time
    logic        wr_req;
    logic        rd_req;

    ////////////////////////////////////////
    // Request decode

    // Host keeps stb up through the ack cycle, so mask it there
    assign req    = wb_cyc_i && wb_stb_i && !ack_q;
    assign wr_req = req && wb_we_i;
    assign rd_req = req && !wb_we_i;

    always_comb begin
        cmd_o                = '0;
        cmd_o.data           = wb_dat_i;
        cmd_o.set_polarity   = wr_req && (wb_adr_i == stepper_pkg::ADDR_POLARITY);
        cmd_o.clear_shutdown = wr_req && (wb_adr_i == stepper_pkg::ADDR_CLR_SHUTDOWN);
        cmd_o.set_step_dur   = wr_req && (wb_adr_i == stepper_pkg::ADDR_STEP_DUR);
        cmd_o.push_move      = wr_req && (wb_adr_i == stepper_pkg::ADDR_PUSH_MOVE);
    end

    // Queue clears its overflow flag on this
    assign status_read_o = rd_req && (wb_adr_i == stepper_pkg::ADDR_STATUS);

    ////////////////////////////////////////
    // Ack and read data

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;   // Also acks unmapped addresses
        end
    end

    // Sampled before the overflow bit is cleared
    always_ff @(posedge clk) begin
        if (rd_req) begin
            if (wb_adr_i == stepper_pkg::ADDR_STATUS)
                rd_data_q <= 32'(status_i);
            else
                rd_data_q <= '0;    // Unmapped reads return zero
        end
    end

    assign wb_ack_o = ack_q;
    assign wb_dat_o = rd_data_q;

    // One ack per strobe, even with stb held high
    a_ack_single: assert property (
        @(posedge clk) disable iff (rst) wb_ack_o |=> !wb_ack_o
    ) else $error("wb_ack_o high for two cycles");

endmodule

//--- verilog/move_queue.sv
// Move FIFO between the host and the step scheduler
// Sends the head entry only while a scheduler credit is held
`timescale 1ns/1ns

module move_queue (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     push_i,
    input  stepper_pkg::move_entry_t entry_i,

    output logic                     move_valid_o,
    output stepper_pkg::move_entry_t move_o,
    input  logic                     credit_return_i,

    output stepper_pkg::qcount_t     free_o,
    output logic                     overflow_o,
    input  logic                     status_read_i
);

    localparam int PTR_W = $clog2(stepper_pkg::QUEUE_DEPTH);
    localparam int CRD_W = $clog2(stepper_pkg::SCHED_CREDITS + 1);

    stepper_pkg::move_entry_t mem [stepper_pkg::QUEUE_DEPTH];
    stepper_pkg::move_entry_t move_q;

    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    stepper_pkg::qcount_t count;
    logic [CRD_W-1:0]     credits;
    logic                 valid_q;
    logic                 overflow_q;

    logic full;
    logic push_ok;
    logic pop;

    assign full    = (count == stepper_pkg::qcount_t'(stepper_pkg::QUEUE_DEPTH));
    assign push_ok = push_i && !full;               // Full queue drops the push
    assign pop     = (count != '0) && (credits != '0);

    ////////////////////////////////////////
    // Storage and output register

    always_ff @(posedge clk) begin
        if (push_ok)
            mem[wr_ptr] <= entry_i;
        if (pop)
            move_q <= mem[rd_ptr];
    end

    ////////////////////////////////////////
    // Pointers, fill level and credits

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRD_W'(stepper_pkg::SCHED_CREDITS);  // Scheduler starts empty
            valid_q <= 1'b0;
        end else begin
            if (push_ok)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count   <= count + stepper_pkg::qcount_t'(push_ok) - stepper_pkg::qcount_t'(pop);
            credits <= credits + CRD_W'(credit_return_i) - CRD_W'(pop);
            valid_q <= pop;
        end
    end

    // Sticky overflow, cleared when the host reads status
    always_ff @(posedge clk) begin
        if (rst)
            overflow_q <= 1'b0;
        else if (push_i && full)
            overflow_q <= 1'b1;
        else if (status_read_i)
            overflow_q <= 1'b0;
    end

    assign move_valid_o = valid_q;
    assign move_o       = move_q;
    assign free_o       = stepper_pkg::qcount_t'(stepper_pkg::QUEUE_DEPTH) - count;
    assign overflow_o   = overflow_q;

    // Credit count stays in range; a wrap below zero also lands above the max
    a_credit_max: assert property (
        @(posedge clk) disable iff (rst) credits <= CRD_W'(stepper_pkg::SCHED_CREDITS)
    ) else $error("move_queue credits above SCHED_CREDITS");

    // Scheduler only returns credits that were spent
    a_credit_spent: assert property (
        @(posedge clk) disable iff (rst)
        credit_return_i |-> (credits != CRD_W'(stepper_pkg::SCHED_CREDITS))
    ) else $error("credit returned with all credits held");

endmodule

//--- verilog/step_scheduler.sv
// Step scheduler: buffers up to two move entries and paces step requests
// Returns one credit to the queue for each retired entry
`timescale 1ns/1ns

module step_scheduler (
    input  logic                     clk,
    input  logic                     rst,

    input  logic                     move_valid_i,
    input  stepper_pkg::move_entry_t move_i,
    output logic                     credit_return_o,

    output logic                     step_req_o,
    output logic                     step_dir_o,
    output logic                     busy_o
);

    localparam int SEL_W  = $clog2(stepper_pkg::SCHED_CREDITS);
    localparam int FILL_W = $clog2(stepper_pkg::SCHED_CREDITS + 1);

    stepper_pkg::move_entry_t slots [stepper_pkg::SCHED_CREDITS];
    stepper_pkg::move_entry_t head;

    logic [SEL_W-1:0]  wr_sel;
    logic [SEL_W-1:0]  rd_sel;
    logic [FILL_W-1:0] fill;

    stepper_pkg::sched_state_e state;
    stepper_pkg::interval_t    timer;      // Cycles left before the next step
    stepper_pkg::step_count_t  remaining;  // Steps left, including the current one
    logic                      dir_q;
    logic                      credit_q;
    logic                      retire;

    // Entry stays in its slot until it retires
    assign head = slots[rd_sel];

    assign retire = ((state == stepper_pkg::IDLE) && (fill != '0) && (head.count == '0))
                 || ((state == stepper_pkg::STEP) && (remaining == 15'd1));

    ////////////////////////////////////////
    // Entry buffer

    always_ff @(posedge clk) begin
        if (move_valid_i)
            slots[wr_sel] <= move_i;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_sel <= '0;
            rd_sel <= '0;
            fill   <= '0;
        end else begin
            if (move_valid_i)
                wr_sel <= wr_sel + 1'b1;
            if (retire)
                rd_sel <= rd_sel + 1'b1;
            fill <= fill + FILL_W'(move_valid_i) - FILL_W'(retire);
        end
    end

    ////////////////////////////////////////
    // Step pacing FSM
    // Timer is loaded with interval-1, so intervals below 2 run slow

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= stepper_pkg::IDLE;
            timer     <= '0;
            remaining <= '0;
            dir_q     <= 1'b0;
            credit_q  <= 1'b0;
        end else begin
            credit_q <= retire;
            case (state)
                stepper_pkg::IDLE: begin
                    if (fill != '0 && head.count != '0) begin
                        dir_q     <= head.dir;
                        timer     <= head.interval - 1'b1;
                        remaining <= head.count;
                        state     <= stepper_pkg::WAIT;
                    end
                end
                stepper_pkg::WAIT: begin
                    if (timer <= 16'd1)
                        state <= stepper_pkg::STEP;
                    else
                        timer <= timer - 1'b1;
                end
                stepper_pkg::STEP: begin
                    remaining <= remaining - 1'b1;
                    timer     <= head.interval - 1'b1;  // Next step, same entry
                    if (remaining == 15'd1)
                        state <= stepper_pkg::IDLE;     // Last step of the move
                    else
                        state <= stepper_pkg::WAIT;
                end
                default: state <= stepper_pkg::IDLE;
            endcase
        end
    end

    assign step_req_o      = (state == stepper_pkg::STEP);
    assign step_dir_o      = dir_q;
    assign credit_return_o = credit_q;
    assign busy_o          = (state != stepper_pkg::IDLE) || (fill != '0);

    // Queue must never send beyond the credits it was given
    a_no_overfill: assert property (
        @(posedge clk) disable iff (rst)
        move_valid_i |-> (fill < FILL_W'(stepper_pkg::SCHED_CREDITS))
    ) else $error("move_valid with scheduler buffer full");

endmodule

//--- verilog/pin_config.sv
// Output pin stage: polarity, timed step pulse, direction latch and shutdown
// Pins 0 and 1 carry step and direction, pins 7..2 only show polarity
`timescale 1ns/1ns

module pin_config (
    input  logic                  clk,
    input  logic                  rst,

    input  stepper_pkg::reg_cmd_t cmd_i,

    input  logic                  step_req_i,
    input  logic                  step_dir_i,

    input  logic                  pin_shutdown_i,
    output logic                  in_shutdown_o,
    output stepper_pkg::pin_vec_t pins_o
);

    stepper_pkg::pin_vec_t  polarity;
    stepper_pkg::step_dur_t step_dur;
    stepper_pkg::step_dur_t dur_count;
    logic                   in_pulse;
    logic                   active_dir;
    logic [1:0]             shutdown_sync;
    logic                   in_shutdown;
    logic                   pulse_on;
    logic                   dir_on;

    ////////////////////////////////////////
    // Host programmed registers

    always_ff @(posedge clk) begin
        if (rst)
            polarity <= '0;
        else if (cmd_i.set_polarity)
            polarity <= stepper_pkg::pin_vec_t'(cmd_i.data[7:0]);
    end

    always_ff @(posedge clk) begin
        if (rst)
            step_dur <= '0;
        else if (cmd_i.set_step_dur)
            step_dur <= stepper_pkg::step_dur_t'(cmd_i.data[15:0]);
    end

    ////////////////////////////////////////
    // Step pulse timing

    assign in_pulse = (dur_count != '0);

    // Requests during an active pulse are lost
    always_ff @(posedge clk) begin
        if (rst)
            dur_count <= '0;
        else if (in_pulse)
            dur_count <= dur_count - 1'b1;
        else if (step_req_i)
            dur_count <= step_dur;      // Zero duration gives no pulse
    end

    // Direction only moves between pulses
    always_ff @(posedge clk) begin
        if (rst)
            active_dir <= 1'b0;
        else if (!in_pulse)
            active_dir <= step_dir_i;
    end

    ////////////////////////////////////////
    // Shutdown tracking

    always_ff @(posedge clk) begin
        if (rst)
            shutdown_sync <= '0;
        else
            shutdown_sync <= {shutdown_sync[0], pin_shutdown_i};  // Async input
    end

    // Sticky until the host clears it
    always_ff @(posedge clk) begin
        if (rst || cmd_i.clear_shutdown)
            in_shutdown <= 1'b0;
        else if (shutdown_sync[1])
            in_shutdown <= 1'b1;
    end

    assign pulse_on = in_pulse && !in_shutdown;
    assign dir_on   = active_dir && !in_shutdown;

    // Pin drive
    assign pins_o[0]   = polarity[0] ^ pulse_on;
    assign pins_o[1]   = polarity[1] ^ dir_on;
    assign pins_o[7:2] = polarity[7:2];

    assign in_shutdown_o = in_shutdown;

endmodule

//--- verilog/stepper_top.sv
// Stepper output subsystem top: Wishbone registers, move queue, scheduler
// and pin stage, wired together with no logic of its own
`timescale 1ns/1ns

module stepper_top (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  wb_cyc_i,
    input  logic                  wb_stb_i,
    input  logic                  wb_we_i,
    input  logic [3:0]            wb_adr_i,
    input  logic [31:0]           wb_dat_i,
    output logic [31:0]           wb_dat_o,
    output logic                  wb_ack_o,

    input  logic                  pin_shutdown_i,
    output stepper_pkg::pin_vec_t pins_o
);

    stepper_pkg::reg_cmd_t    cmd;
    stepper_pkg::status_t     status;
    logic                     status_read;

    stepper_pkg::move_entry_t move;
    logic                     move_valid;
    logic                     credit_return;
    stepper_pkg::qcount_t     q_free;
    logic                     q_overflow;

    logic                     step_req;
    logic                     step_dir;
    logic                     sched_busy;
    logic                     in_shutdown;

    // Status word gathered from the three blocks
    assign status = '{free: q_free, in_shutdown: in_shutdown,
                      busy: sched_busy, overflow: q_overflow};

    wb_stepper_regs u_regs (
        .clk           (clk),
        .rst           (rst),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .cmd_o         (cmd),
        .status_i      (status),
        .status_read_o (status_read)
    );

    move_queue u_queue (
        .clk             (clk),
        .rst             (rst),
        .push_i          (cmd.push_move),
        .entry_i         (stepper_pkg::move_entry_t'(cmd.data)),
        .move_valid_o    (move_valid),
        .move_o          (move),
        .credit_return_i (credit_return),
        .free_o          (q_free),
        .overflow_o      (q_overflow),
        .status_read_i   (status_read)
    );

    step_scheduler u_sched (
        .clk             (clk),
        .rst             (rst),
        .move_valid_i    (move_valid),
        .move_i          (move),
        .credit_return_o (credit_return),
        .step_req_o      (step_req),
        .step_dir_o      (step_dir),
        .busy_o          (sched_busy)
    );

    pin_config u_pins (
        .clk            (clk),
        .rst            (rst),
        .cmd_i          (cmd),
        .step_req_i     (step_req),
        .step_dir_i     (step_dir),
        .pin_shutdown_i (pin_shutdown_i),
        .in_shutdown_o  (in_shutdown),
        .pins_o         (pins_o)
    );

endmodule

//--- verification/tb_clock.sv
// Testbench clock and reset source
// 8 ns clock period, reset held high for the first 10 rising edges
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;     // Half of the 8 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (10) @(posedge clk_o);
        #1 rst_o = 1'b0;               // Released off the edge, like other inputs
    end

endmodule

//--- verification/stepper_tb.sv
// Testbench for the stepper output subsystem that drives the Wishbone registers,
// watches the step and direction pins and checks them with assertions
`timescale 1ns/1ns

module stepper_tb;

    logic                  clk;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [3:0]            wb_adr;
    logic [31:0]           wb_dat;
    logic [31:0]           wb_rdata;
    logic                  wb_ack;
    logic                  shutdown;
    stepper_pkg::pin_vec_t pins;

    // What the host has written so far
    stepper_pkg::pin_vec_t  pol_exp = '0;
    stepper_pkg::step_dur_t dur_exp = '0;

    // Moves still owed to the pins with nonzero counts
    logic exp_dirs[$];
    int   exp_left[$];

    integer seed           = 32'h735ed8b0;
    int     errors         = 0;
    int     test_base      = 0;
    int     tests_run      = 0;
    int     steps_expected = 0;
    int     pulses_seen    = 0;
    int     budget         = 3000;   // Watchdog limit in cycles that grows per move
    int     cycles         = 0;

    logic step_act;     // Step pin with polarity removed
    logic dir_act;
    logic act_d;
    int   pulse_len;

    tb_clock u_clock (.clk_o(clk), .rst_o(rst));

    stepper_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .wb_cyc_i       (wb_cyc),
        .wb_stb_i       (wb_stb),
        .wb_we_i        (wb_we),
        .wb_adr_i       (wb_adr),
        .wb_dat_i       (wb_dat),
        .wb_dat_o       (wb_rdata),
        .wb_ack_o       (wb_ack),
        .pin_shutdown_i (shutdown),
        .pins_o         (pins)
    );

    assign step_act = pins[0] ^ pol_exp[0];
    assign dir_act  = pins[1] ^ pol_exp[1];

    task automatic log_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////
    // Bus and pin checks

    a_ack_next: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> wb_ack)
        else log_error("strobe not acked in the next cycle");

    a_ack_once: assert property (@(posedge clk) disable iff (rst)
        wb_ack |-> ($past(wb_stb) && !$past(wb_ack)))
        else log_error("ack without a fresh strobe");

    a_pulse_width: assert property (@(posedge clk) disable iff (rst)
        $fell(step_act) |-> (pulse_len == int'(dur_exp)))
        else log_error("step pulse width differs from the duration register");

    a_dir_stable: assert property (@(posedge clk) disable iff (rst)
        (step_act && $past(step_act)) |-> $stable(dir_act))
        else log_error("direction pin moved during a step pulse");

    // Pulse counter and per move direction scoreboard
    always @(posedge clk) begin
        if (rst) begin
            act_d     <= 1'b0;
            pulse_len <= 0;
        end else begin
            act_d     <= step_act;
            pulse_len <= step_act ? pulse_len + 1 : 0;
            if (step_act && !act_d) begin
                pulses_seen++;
                if (exp_dirs.size() == 0) begin
                    errors++;
                    $display("Step pulse at %0t with no move left to play", $time);
                end else begin
                    a_move_dir: assert (dir_act == exp_dirs[0])
                        else log_error("direction pin differs from the move dir");
                    exp_left[0] = exp_left[0] - 1;
                    if (exp_left[0] == 0) begin
                        exp_dirs.delete(0);
                        exp_left.delete(0);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles <= budget) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the run did not finish", cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////
    // Host tasks

    // One Wishbone access with inputs changing 1 ns after the edge
    task automatic bus_access(input logic we, input logic [3:0] adr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        waited = 0;
        rdata  = '0;
        @(posedge clk);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        wb_dat = wdata;
        while (!wb_ack && waited < 4) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wb_ack) begin
            rdata = wb_rdata;
        end else begin
            errors++;
            $display("Bus access to address %0d at %0t got no ack", adr, $time);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_status(output stepper_pkg::status_t st);
        logic [31:0] r;
        bus_access(1'b0, stepper_pkg::ADDR_STATUS, '0, r);
        st = stepper_pkg::status_t'(r[$bits(stepper_pkg::status_t)-1:0]);
    endtask

    // Word layout is interval [31:16], count [15:1], dir [0]
    task automatic push_move(input stepper_pkg::interval_t interval,
                             input stepper_pkg::step_count_t count,
                             input logic dir, input logic accepted);
        write_reg(stepper_pkg::ADDR_PUSH_MOVE, {interval, count, dir});
        budget += int'(interval) * int'(count) + 64;
        if (accepted) begin
            steps_expected += int'(count);
            if (count != '0) begin
                exp_dirs.push_back(dir);
                exp_left.push_back(int'(count));
            end
        end
    endtask

    // Two idle reads in a row and then room for the last pulse
    task automatic wait_idle();
        stepper_pkg::status_t st;
        int idle_reads;
        idle_reads = 0;
        while (idle_reads < 2) begin
            read_status(st);
            if (!st.busy && st.free == stepper_pkg::qcount_t'(stepper_pkg::QUEUE_DEPTH))
                idle_reads++;
            else
                idle_reads = 0;
        end
        repeat (int'(dur_exp) + 2) @(posedge clk);
        #1;
    endtask

    task automatic check_steps();
        a_step_total: assert (pulses_seen == steps_expected)
            else log_error($sformatf("%0d step pulses, expected %0d",
                                     pulses_seen, steps_expected));
        a_moves_done: assert (exp_dirs.size() == 0)
            else log_error("moves left without their step pulses");
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        $display("Test %s done with %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    ////////////////////////////////////////
    // Test sequence

    initial begin : stimulus
        stepper_pkg::status_t   st;
        stepper_pkg::pin_vec_t  pol;
        stepper_pkg::interval_t interval;
        int                     i;
        int                     n;
        int                     limit;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat   = '0;
        shutdown = 1'b0;
        @(negedge rst);

        pol = stepper_pkg::pin_vec_t'($random(seed));
        write_reg(stepper_pkg::ADDR_POLARITY, 32'(pol));
        pol_exp = pol;
        a_pol: assert (pins == pol)
            else log_error($sformatf("pins %h, expected %h", pins, pol));
        finish_test("polarity");

        // Pulses of 3 or more cycles still run when the next move loads its dir
        dur_exp = stepper_pkg::step_dur_t'(3 + ($random(seed) & 3));
        write_reg(stepper_pkg::ADDR_STEP_DUR, 32'(dur_exp));
        for (i = 0; i < 6; i++) begin
            interval = stepper_pkg::interval_t'(dur_exp + 3 + ($random(seed) & 15));
            push_move(interval, $random(seed) & 3, $random(seed) & 1, 1'b1);
        end
        wait_idle();
        check_steps();
        finish_test("steps and direction");

        // Long move so the direction pin is active when shutdown hits
        push_move(16'd200, 15'd1, 1'b1, 1'b1);
        n = 0;
        while (dir_act !== 1'b1 && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (dir_act !== 1'b1) begin
            errors++;
            $display("Direction pin never went active before shutdown");
        end
        shutdown = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        a_forced: assert (pins[1:0] == pol_exp[1:0])
            else log_error("pins 0 and 1 not forced inactive by shutdown");
        read_status(st);
        a_sd_flag: assert (st.in_shutdown) else log_error("status lacks in_shutdown");
        shutdown = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        a_sticky: assert (pins[1:0] == pol_exp[1:0])
            else log_error("pins resumed before the clear write");
        write_reg(stepper_pkg::ADDR_CLR_SHUTDOWN, '0);
        a_resume: assert (dir_act == 1'b1)
            else log_error("direction pin did not resume after clear");
        read_status(st);
        a_sd_clear: assert (!st.in_shutdown) else log_error("in_shutdown still set");
        wait_idle();
        check_steps();
        finish_test("shutdown");

        // Queue plus scheduler buffer hold the first pushes and the rest drop
        limit = stepper_pkg::QUEUE_DEPTH + stepper_pkg::SCHED_CREDITS;
        for (i = 0; i < limit + 2; i++)
            push_move(16'd40, 15'd2, $random(seed) & 1, i < limit);
        read_status(st);
        a_ovf_set: assert (st.overflow && st.free == '0)
            else log_error("overflow not flagged with a full queue");
        read_status(st);
        a_ovf_clr: assert (!st.overflow) else log_error("overflow not cleared by read");
        wait_idle();
        check_steps();
        finish_test("back-pressure");

        write_reg(4'd9, 32'hFFFF_FFFF);    // Unmapped
        read_status(st);
        a_idle: assert (st.free == stepper_pkg::qcount_t'(stepper_pkg::QUEUE_DEPTH)
                        && !st.busy && !st.overflow && !st.in_shutdown)
            else log_error($sformatf("idle status %h", st));
        a_static: assert (pins[7:2] == pol_exp[7:2])
            else log_error("static pins changed by an unmapped write");
        finish_test("bus");

        $display("Summary: %0d tests, %0d of %0d steps seen, %0d errors",
                 tests_run, pulses_seen, steps_expected, errors);
        if (errors == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- stepper_top.f
verilog/stepper_pkg.sv
verilog/wb_stepper_regs.sv
verilog/move_queue.sv
verilog/step_scheduler.sv
verilog/pin_config.sv
verilog/stepper_top.sv
verification/tb_clock.sv
verification/stepper_tb.sv

//--- Bender.yml
package:
  name: stepper_top

sources:
  - files:
      - verilog/stepper_pkg.sv
      - verilog/wb_stepper_regs.sv
      - verilog/move_queue.sv
      - verilog/step_scheduler.sv
      - verilog/pin_config.sv
      - verilog/stepper_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/stepper_tb.sv
